//--- design/burstSequencer.sv
`include "octalRam_params.svh"

module burstSequencer (
	input logic iClk,
	input logic iRst_N,
	input octalRamPkg::opCode_t opCode,
	input octalRamPkg::seqPlan_t seqPlan,
	output logic [2:0] stepIndex,
	output octalRamPkg::psramBus_t psramOut,
	output logic captureStart, // first bus cycle after the address of a read.
	output logic stepEnd, // last bus cycle of a frame.
	output logic opDone
);
	import octalRamPkg::*;

	localparam int CntW = $clog2(`OR_RESET_WAIT + 1); // power wait is the longest phase.

	seqPhase_t phase;
	seqPhase_t phaseNext;
	logic [CntW-1:0] cnt; // cycles spent in the current phase.
	logic [CntW-1:0] phaseLen;
	logic phaseDone;
	logic armed;
	logic start;
	psramBus_t busNext;

	assign start = armed && (opCode != opIdle) && (phase == phIdle);
	assign phaseDone = (cnt == phaseLen - 1'b1);

	// length of each phase in cycles.
	always_comb
	begin
		case (phase)
			phPowerWait:
				phaseLen = CntW'(`OR_RESET_WAIT);
			phAddress:
				phaseLen = CntW'(2); // four address bytes over two cycles.
			phLatency:
				// reads get one more cycle so the last capture lands inside the frame.
				if (!seqPlan.isRead)
					phaseLen = CntW'(`OR_WR_LATENCY);
				else if (seqPlan.op == opModeRead)
					phaseLen = CntW'(`OR_MR_LATENCY + 1);
				else
					phaseLen = CntW'(`OR_RD_LATENCY + 1);
			phData:
				phaseLen = (seqPlan.op == opBurstRead) ? CntW'(`OR_RD_WORDS) : CntW'(1);
			default:
				phaseLen = CntW'(1);
		endcase
	end

	always_comb
	begin
		phaseNext = phase;
		case (phase)
			phIdle:
				if (start)
					phaseNext = (opCode == opResetIc) ? phPowerWait : phCommand;
			phPowerWait:
				if (phaseDone)
					phaseNext = phResetPulse;
			phResetPulse:
				phaseNext = phClose;
			phCommand:
				phaseNext = phAddress;
			phAddress:
				if (phaseDone)
					phaseNext = (seqPlan.op == opModeWrite) ? phData : phLatency; // latency 1.
			phLatency:
				if (phaseDone)
					phaseNext = phData;
			phData:
				if (phaseDone)
					phaseNext = phClose;
			phClose:
				phaseNext = seqPlan.lastStep ? phIdle : phCommand;
			default:
				phaseNext = phIdle;
		endcase
	end

	// bus contents for the next cycle.
	always_comb
	begin
		busNext = BusIdle;
		case (phase)
			phResetPulse:
				busNext.rstN = 1'b0; // ce# stays high.
			phCommand:
			begin
				busNext.ceN = 1'b0;
				busNext.dqOe = 1'b1;
				busNext.rise = seqPlan.cmd; // same byte on both edges.
				busNext.fall = seqPlan.cmd;
			end
			phAddress:
			begin
				busNext.ceN = 1'b0;
				busNext.dqOe = 1'b1;
				busNext.rise = cnt[0] ? seqPlan.addr[15:8] : seqPlan.addr[31:24]; // msb first.
				busNext.fall = cnt[0] ? seqPlan.addr[7:0] : seqPlan.addr[23:16];
			end
			phLatency, phData:
			begin
				busNext.ceN = 1'b0;
				busNext.dqOe = !seqPlan.isRead; // release dq for reads.
				busNext.dqsOe = (seqPlan.op != opBurstRead); // memory drives dqs.
				if (phase == phData && !seqPlan.isRead)
				begin
					busNext.rise = seqPlan.wrWord[15:8];
					busNext.fall = seqPlan.wrWord[7:0];
				end
			end
			default:
				busNext = BusIdle; // power wait and close.
		endcase
	end

	always_ff @(posedge iClk or negedge iRst_N)
	begin
		if (!iRst_N)
		begin
			phase <= phIdle;
			cnt <= '0;
			armed <= 1'b1;
			stepIndex <= '0;
			psramOut <= BusIdle;
			captureStart <= 1'b0;
			stepEnd <= 1'b0;
			opDone <= 1'b0;
		end
		else
		begin
			phase <= phaseNext;
			cnt <= phaseDone ? '0 : cnt + 1'b1; // every phase leaves when done.
			psramOut <= busNext;
			captureStart <= (phase == phLatency) && (cnt == '0) && seqPlan.isRead;
			stepEnd <= (phase == phData) && phaseDone;
			opDone <= (phase == phClose) && seqPlan.lastStep; // with ce# back high.
			if (opCode == opIdle)
				armed <= 1'b1;
			else if (start)
				armed <= 1'b0; // one run per op code.
			if (phase == phClose)
				stepIndex <= seqPlan.lastStep ? '0 : stepIndex + 1'b1;
		end
	end

endmodule

//--- design/octalRamOperator.sv
`include "octalRam_params.svh"

module octalRamOperator (
	input logic iClk,
	input logic iRst_N,
	input octalRamPkg::opCode_t opCode, // level, back to idle after opDone.
	input logic [`OR_ADDR_W-1:0] address,
	input logic [`OR_DATA_W-1:0] wrData,
	input octalRamPkg::psramIn_t psramIn, // ddr bytes from the pads.
	output logic opDone,
	output logic [`OR_DATA_W-1:0] rdData,
	output octalRamPkg::psramBus_t psramOut,
	output octalRamPkg::ebrWrite_t ebrWr
);
	import octalRamPkg::*;

	seqPlan_t seqPlan;
	logic [2:0] stepIndex;
	logic captureStart;
	logic stepEnd;

	// op code, address and table entry for the current step.
	opDecoder uDecoder (
		.iClk(iClk),
		.iRst_N(iRst_N),
		.opCode(opCode),
		.address(address),
		.wrData(wrData),
		.stepIndex(stepIndex),
		.seqPlan(seqPlan)
	);

	// frames on the psram bus.
	burstSequencer uSequencer (
		.iClk(iClk),
		.iRst_N(iRst_N),
		.opCode(opCode),
		.seqPlan(seqPlan),
		.stepIndex(stepIndex),
		.psramOut(psramOut),
		.captureStart(captureStart),
		.stepEnd(stepEnd),
		.opDone(opDone)
	);

	// read data into block ram.
	readCapture uCapture (
		.iClk(iClk),
		.iRst_N(iRst_N),
		.seqPlan(seqPlan),
		.captureStart(captureStart),
		.stepEnd(stepEnd),
		.psramIn(psramIn),
		.ebrWr(ebrWr),
		.rdData(rdData)
	);

endmodule

//--- design/octalRamPkg.sv
`include "octalRam_params.svh"

package octalRamPkg;

	// operation requested by the host, held as a level.
	typedef enum logic [2:0] {
		opIdle = 3'd0,
		opResetIc = 3'd1, // power-up wait and rst# pulse.
		opModeWrite = 3'd2, // walk the write half of the table.
		opModeRead = 3'd3, // read mode registers into block ram.
		opBurstWrite = 3'd4, // one word at address.
		opBurstRead = 3'd5 // OR_RD_WORDS words into block ram.
	} opCode_t;

	// psram instruction bytes, sent on both edges.
	typedef enum logic [7:0] {
		cmdBurstRead = 8'h20,
		cmdBurstWrite = 8'hA0,
		cmdModeRead = 8'h40,
		cmdModeWrite = 8'hC0
	} psramCmd_t;

	// sequencer phases.
	typedef enum logic [2:0] {
		phIdle, phPowerWait, phResetPulse, phCommand, phAddress, phLatency, phData, phClose
	} seqPhase_t;

	// what the current step has to put on the bus.
	typedef struct packed {
		opCode_t op;
		psramCmd_t cmd;
		logic [`OR_ADDR_W-1:0] addr; // mode accesses use the low byte only.
		logic [`OR_DATA_W-1:0] wrWord; // mode data sits in the high byte.
		logic isRead;
		logic lastStep; // last table entry, or a single-step op.
	} seqPlan_t;

	// pins toward the memory, ddr bytes split by edge.
	typedef struct packed {
		logic ceN;
		logic rstN;
		logic dqOe; // dq driven by us.
		logic dqsOe; // dqs/dm driven by us.
		logic dqsDm; // dm=1 masks the write byte.
		logic [7:0] rise;
		logic [7:0] fall;
	} psramBus_t;

	typedef struct packed {
		logic [7:0] rise;
		logic [7:0] fall;
	} psramIn_t;

	typedef struct packed {
		logic en;
		logic [`OR_EBR_AW-1:0] addr;
		logic [`OR_DATA_W-1:0] data;
	} ebrWrite_t;

	// bus state between frames.
	localparam psramBus_t BusIdle = '{ceN: 1'b1, rstN: 1'b1, dqOe: 1'b0, dqsOe: 1'b1,
		dqsDm: 1'b0, rise: 8'h00, fall: 8'h00};

endpackage

//--- design/octalRam_params.svh
`ifndef OCTALRAM_PARAMS_SVH
`define OCTALRAM_PARAMS_SVH

// bus widths.
`define OR_ADDR_W 32 // psram byte address.
`define OR_DATA_W 16 // one ddr word, rise byte on top.
`define OR_EBR_AW 9 // block ram address, 512 words.

// power-up wait before the reset pulse.
// device tPU is 150us; the count assumes a slow fabric clock.
`define OR_RESET_WAIT 100

// filler cycles between the last address byte and the write word.
`define OR_WR_LATENCY 5

// cycles from the end of a mode-register address to its data.
`define OR_MR_LATENCY 9

// cycles from the end of a burst-read address to the first word.
`define OR_RD_LATENCY 1

// burst read length in words.
`define OR_RD_WORDS 20

// mode-register table sizes.
`define OR_MR_WR_COUNT 4
`define OR_MR_RD_COUNT 6

// high byte put on mode-register read-back so it is easy to spot in block ram.
`define OR_MR_TAG 8'h55

`endif

//--- design/opDecoder.sv
`include "octalRam_params.svh"

module opDecoder (
	input logic iClk,
	input logic iRst_N,
	input octalRamPkg::opCode_t opCode,
	input logic [`OR_ADDR_W-1:0] address,
	input logic [`OR_DATA_W-1:0] wrData,
	input logic [2:0] stepIndex, // table position from the sequencer.
	output octalRamPkg::seqPlan_t seqPlan
);
	import octalRamPkg::*;

	localparam int TableSize = `OR_MR_WR_COUNT + `OR_MR_RD_COUNT;
	localparam int IdxW = $clog2(TableSize);

	// {register address, register data}; write pairs first, then read addresses.
	localparam logic [15:0] ModeTable [TableSize] = '{
		16'h0011, // mr0, drive strength and read latency.
		16'h0420, // mr4, write latency.
		16'h0803, // mr8, burst length.
		16'h0600, // mr6 cleared.
		16'h0000, // read entries carry no data.
		16'h0100,
		16'h0200,
		16'h0300,
		16'h0400,
		16'h0800
	};

	logic armed; // set by idle, cleared by a capture.
	logic capture;
	opCode_t opReg;
	logic [`OR_ADDR_W-1:0] addrReg;
	logic [`OR_DATA_W-1:0] wordReg;
	logic [IdxW-1:0] tableIdx;
	logic [15:0] entry;
	logic isMode;
	psramCmd_t cmd;
	logic lastStep;

	// same arming rule as the sequencer, so both see the same start.
	assign capture = armed && (opCode != opIdle);

	always_ff @(posedge iClk or negedge iRst_N)
	begin
		if (!iRst_N)
		begin
			armed <= 1'b1;
			opReg <= opIdle;
		end
		else
		begin
			if (capture)
				opReg <= opCode;
			if (opCode == opIdle)
				armed <= 1'b1;
			else if (capture)
				armed <= 1'b0;
		end
	end

	always_ff @(posedge iClk)
	begin
		if (capture)
		begin
			addrReg <= address; // held for the whole op.
			wordReg <= wrData;
		end
	end

	assign isMode = (opReg == opModeWrite) || (opReg == opModeRead);
	// reads index past the write pairs.
	assign tableIdx = IdxW'(stepIndex) + ((opReg == opModeRead) ? IdxW'(`OR_MR_WR_COUNT) : '0);
	assign entry = ModeTable[tableIdx];

	always_comb
	begin
		case (opReg)
			opModeWrite:
			begin
				cmd = cmdModeWrite;
				lastStep = (stepIndex == 3'(`OR_MR_WR_COUNT - 1));
			end
			opModeRead:
			begin
				cmd = cmdModeRead;
				lastStep = (stepIndex == 3'(`OR_MR_RD_COUNT - 1));
			end
			opBurstWrite:
			begin
				cmd = cmdBurstWrite;
				lastStep = 1'b1;
			end
			default:
			begin
				cmd = cmdBurstRead; // reset ic never sends a command.
				lastStep = 1'b1;
			end
		endcase
	end

	always_comb
	begin
		seqPlan.op = opReg;
		seqPlan.cmd = cmd;
		seqPlan.addr = isMode ? {{(`OR_ADDR_W - 8){1'b0}}, entry[15:8]} : addrReg;
		seqPlan.wrWord = isMode ? {entry[7:0], 8'h00} : wordReg; // mode data on rise only.
		seqPlan.isRead = (opReg == opModeRead) || (opReg == opBurstRead);
		seqPlan.lastStep = lastStep;
	end

endmodule

//--- design/readCapture.sv
`include "octalRam_params.svh"

module readCapture (
	input logic iClk,
	input logic iRst_N,
	input octalRamPkg::seqPlan_t seqPlan,
	input logic captureStart,
	input logic stepEnd,
	input octalRamPkg::psramIn_t psramIn,
	output octalRamPkg::ebrWrite_t ebrWr,
	output logic [`OR_DATA_W-1:0] rdData // first word of the last burst read.
);
	import octalRamPkg::*;

	localparam int MaxLat = (`OR_MR_LATENCY > `OR_RD_LATENCY) ? `OR_MR_LATENCY : `OR_RD_LATENCY;
	localparam int LatW = $clog2(MaxLat + 1);
	localparam int WordW = $clog2(`OR_RD_WORDS + 1);

	logic isModeRead;
	logic waiting; // counting down the read latency.
	logic streaming; // burst words after the first.
	logic take; // psramIn holds a valid word this cycle.
	logic [LatW-1:0] latCnt;
	logic [WordW-1:0] wordCnt;
	logic [`OR_EBR_AW-1:0] baseAddr;
	logic ebrEn;
	logic [`OR_EBR_AW-1:0] ebrAddr;
	logic [`OR_DATA_W-1:0] ebrData;

	assign isModeRead = (seqPlan.op == opModeRead);
	assign take = (waiting && latCnt == '0) || streaming;
	assign ebrWr = '{en: ebrEn, addr: ebrAddr, data: ebrData};

	always_ff @(posedge iClk or negedge iRst_N)
	begin
		if (!iRst_N)
		begin
			waiting <= 1'b0;
			streaming <= 1'b0;
			latCnt <= '0;
			wordCnt <= '0;
			baseAddr <= '0;
			ebrEn <= 1'b0;
		end
		else
		begin
			ebrEn <= take;
			if (captureStart)
			begin
				waiting <= 1'b1;
				latCnt <= isModeRead ? LatW'(`OR_MR_LATENCY - 1) : LatW'(`OR_RD_LATENCY - 1);
			end
			else if (waiting)
			begin
				if (latCnt == '0)
				begin
					waiting <= 1'b0;
					streaming <= !isModeRead && (`OR_RD_WORDS > 1); // mode read is one byte.
					wordCnt <= WordW'(`OR_RD_WORDS - 1);
				end
				else
					latCnt <= latCnt - 1'b1;
			end
			else if (streaming)
			begin
				wordCnt <= wordCnt - 1'b1;
				if (wordCnt == WordW'(1))
					streaming <= 1'b0;
			end
			// mode read steps one address per frame, bursts one per word.
			if (stepEnd)
				baseAddr <= seqPlan.lastStep ? '0 : baseAddr + 1'b1;
			else if (take && !isModeRead)
				baseAddr <= baseAddr + 1'b1;
		end
	end

	always_ff @(posedge iClk)
	begin
		if (take)
		begin
			ebrAddr <= baseAddr;
			// only the falling byte is valid on a mode read.
			ebrData <= isModeRead ? {`OR_MR_TAG, psramIn.fall} : {psramIn.rise, psramIn.fall};
		end
		if (take && waiting && !isModeRead)
			rdData <= {psramIn.rise, psramIn.fall};
	end

endmodule

//--- octalRam.f
+incdir+design
design/octalRamPkg.sv
design/opDecoder.sv
design/burstSequencer.sv
design/readCapture.sv
design/octalRamOperator.sv
verif/octalRam_checker.sv
verif/octalRamTb.sv

//--- run.sh
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module octalRamTb -f octalRam.f --Mdir obj_dir -o octalRamSim \
	|| { echo "build failed"; exit 1; }
out=$(./obj_dir/octalRamSim 2>&1)
echo "$out"
echo "$out" | grep -qx "All tests passed" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- verif/octalRamTb.sv
`include "octalRam_params.svh"

module octalRamTb;
	import octalRamPkg::*;

	localparam int ResetCycles = 10;
	localparam int CyclesPerVector = `OR_RESET_WAIT + 200;
	localparam int DataIdx = 3 + `OR_WR_LATENCY; // frame cycle of the write word.

	logic iClk;
	logic iRst_N;
	opCode_t opCode;
	logic [`OR_ADDR_W-1:0] address;
	logic [`OR_DATA_W-1:0] wrData;
	psramIn_t psramIn;
	logic opDone;
	logic [`OR_DATA_W-1:0] rdData;
	psramBus_t psramOut;
	ebrWrite_t ebrWr;

	logic [2:0] vecOp[$]; // one entry per vector line.
	logic [`OR_ADDR_W-1:0] vecAddr[$];
	logic [`OR_DATA_W-1:0] vecData[$];
	logic [15:0] vecPair[$]; // {rise, fall} the memory returns.
	int vecCount;
	logic loaded = 1'b0;

	int opIndex;
	opCode_t curOp;
	logic [`OR_ADDR_W-1:0] curAddr;
	logic [`OR_DATA_W-1:0] curData;
	logic [15:0] curPair;
	logic [15:0] heldWord; // first word of the last burst read.
	logic heldValid;
	logic monitorOn;
	logic prevCeN;
	int frameCount;
	int frameIdx; // cycle inside the current ceN-low frame.
	int lowCycles;
	int rstLowCount;
	int ebrCount;
	int doneCount;
	psramBus_t expBus;
	ebrWrite_t expEbr;
	logic careBytes;
	int busErrors;
	int ebrErrors;
	int wordErrors;
	int otherErrors;

	octalRamOperator DUT (
		.iClk(iClk),
		.iRst_N(iRst_N),
		.opCode(opCode),
		.address(address),
		.wrData(wrData),
		.psramIn(psramIn),
		.opDone(opDone),
		.rdData(rdData),
		.psramOut(psramOut),
		.ebrWr(ebrWr)
	);

	bind octalRamOperator octalRam_checker uChecker (
		.iClk(iClk),
		.iRst_N(iRst_N),
		.opDone(opDone),
		.psramOut(psramOut),
		.ebrWr(ebrWr)
	);

	always #5 iClk = ~iClk;

	// instruction byte for each op code.
	function automatic psramCmd_t cmdFor(input opCode_t op);
		case (op)
			opModeWrite: return cmdModeWrite;
			opModeRead: return cmdModeRead;
			opBurstWrite: return cmdBurstWrite;
			default: return cmdBurstRead;
		endcase
	endfunction

	// control lines are always compared and data bytes only when known.
	task automatic checkBus(input string name, input psramBus_t exp, input psramBus_t act,
		input logic care);
		if ({act.ceN, act.rstN, act.dqOe, act.dqsOe, act.dqsDm}
			!== {exp.ceN, exp.rstN, exp.dqOe, exp.dqsOe, exp.dqsDm}
			|| (care && {act.rise, act.fall} !== {exp.rise, exp.fall}))
		begin
			$display("FAIL time %0t: %s expected %h, got %h", $time, name, exp, act);
			busErrors++;
		end
	endtask

	task automatic checkEbr(input string name, input ebrWrite_t exp, input ebrWrite_t act);
		if (act !== exp)
		begin
			$display("FAIL time %0t: %s expected %h, got %h", $time, name, exp, act);
			ebrErrors++;
		end
	endtask

	task automatic checkWord(input string name, input logic [`OR_DATA_W-1:0] exp,
		input logic [`OR_DATA_W-1:0] act);
		if (act !== exp)
		begin
			$display("FAIL time %0t: %s expected %h, got %h", $time, name, exp, act);
			wordErrors++;
		end
	endtask

	task automatic compareCount(input string what, input int got, input int want);
		if (got != want)
		begin
			$display("vector %0d (op %0d) gave %0d %s where %0d were expected",
				opIndex, curOp, got, what, want);
			otherErrors++;
		end
	endtask

	task automatic loadVectors();
		int fd;
		int n;
		string line;
		logic [31:0] op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] rise;
		logic [31:0] fall;
		fd = $fopen("verif/octalRam_vectors.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the vector file verif/octalRam_vectors.txt");
			otherErrors++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				void'($fgets(line, fd));
				n = $sscanf(line, "%h %h %h %h %h", op, addr, data, rise, fall);
				if (n == 5) // comment and blank lines do not scan.
				begin
					vecOp.push_back(op[2:0]);
					vecAddr.push_back(addr);
					vecData.push_back(data[15:0]);
					vecPair.push_back({rise[7:0], fall[7:0]});
				end
			end
			$fclose(fd);
			if (vecOp.size() == 0)
			begin
				$display("the vector file holds no vectors");
				otherErrors++;
			end
		end
		vecCount = vecOp.size();
	endtask

	// runs one operation and tallies its frames after an idle gap.
	task automatic runOp(input int n);
		int gap;
		int wantFrames;
		int wantWrites;
		@(posedge iClk);
		#1;
		opIndex = n;
		curOp = opCode_t'(vecOp[n]);
		curAddr = vecAddr[n];
		curData = vecData[n];
		curPair = vecPair[n];
		frameCount = 0;
		lowCycles = 0;
		rstLowCount = 0;
		ebrCount = 0;
		doneCount = 0;
		opCode = curOp;
		address = curAddr;
		wrData = curData;
		@(negedge iClk);
		while (!opDone)
			@(negedge iClk);
		@(posedge iClk);
		#1;
		opCode = opIdle; // re-arms the sequencer.
		gap = 2 + int'($urandom % 7);
		repeat (gap)
			@(posedge iClk);
		case (curOp)
			opResetIc: wantFrames = 0;
			opModeWrite: wantFrames = `OR_MR_WR_COUNT;
			opModeRead: wantFrames = `OR_MR_RD_COUNT;
			default: wantFrames = 1;
		endcase
		case (curOp)
			opModeRead: wantWrites = `OR_MR_RD_COUNT;
			opBurstRead: wantWrites = `OR_RD_WORDS;
			default: wantWrites = 0;
		endcase
		compareCount("ceN-low frames", frameCount, wantFrames);
		compareCount("rstN-low cycles", rstLowCount, (curOp == opResetIc) ? 1 : 0);
		compareCount("block ram writes", ebrCount, wantWrites);
		compareCount("opDone pulses", doneCount, 1);
		if (curOp == opBurstWrite)
			compareCount("burst write frame cycles", lowCycles, DataIdx + 1);
		if (curOp == opBurstRead)
		begin
			heldWord = curPair;
			heldValid = 1'b1;
		end
		if (heldValid)
			checkWord("rdData", heldWord, rdData); // held across other ops too.
	endtask

	// memory drives the pair while dq is turned around.
	always @(posedge iClk)
	begin
		#1;
		if (!psramOut.ceN && !psramOut.dqOe)
			psramIn = psramIn_t'(curPair);
		else
			psramIn = '0;
	end

	// bus and block ram monitor sampled mid-cycle.
	always @(negedge iClk)
	begin
		if (monitorOn)
		begin
			expBus = '{ceN: 1'b1, rstN: 1'b1, dqOe: 1'b0, dqsOe: 1'b1, dqsDm: 1'b0,
				rise: 8'h00, fall: 8'h00};
			careBytes = 1'b0;
			if (!psramOut.ceN)
			begin
				if (prevCeN)
				begin
					frameCount++;
					frameIdx = 0;
				end
				else
					frameIdx++;
				lowCycles++;
				expBus.ceN = 1'b0;
				expBus.dqOe = 1'b1;
				careBytes = 1'b1;
				if (frameIdx == 0)
				begin
					expBus.rise = cmdFor(curOp); // command on both edges.
					expBus.fall = cmdFor(curOp);
				end
				else if (frameIdx <= 2 && (curOp == opBurstWrite || curOp == opBurstRead))
				begin
					expBus.rise = (frameIdx == 1) ? curAddr[31:24] : curAddr[15:8];
					expBus.fall = (frameIdx == 1) ? curAddr[23:16] : curAddr[7:0];
				end
				else if (frameIdx == 2)
					careBytes = 1'b0; // register address comes from the table.
				else if (frameIdx > 2 && curOp == opBurstWrite)
				begin
					if (frameIdx == DataIdx)
					begin
						expBus.rise = curData[15:8];
						expBus.fall = curData[7:0];
					end
				end
				else if (frameIdx > 2 && curOp == opModeWrite)
					careBytes = 1'b0;
				else if (frameIdx > 2)
				begin
					expBus.dqOe = 1'b0; // read turnaround.
					expBus.dqsOe = (curOp != opBurstRead);
					careBytes = 1'b0;
				end
			end
			else if (!psramOut.rstN)
			begin
				rstLowCount++;
				expBus.rstN = 1'b0; // tallied against the op after done.
			end
			checkBus("psramOut", expBus, psramOut, careBytes);
			prevCeN = psramOut.ceN;
			if (ebrWr.en)
			begin
				expEbr.en = 1'b1;
				expEbr.addr = `OR_EBR_AW'(ebrCount); // step or word number.
				expEbr.data = (curOp == opModeRead) ? {`OR_MR_TAG, curPair[7:0]} : curPair;
				checkEbr("ebrWr", expEbr, ebrWr);
				ebrCount++;
			end
			if (opDone)
				doneCount++;
		end
	end

	// watchdog scaled by the vector count.
	initial
	begin
		wait (loaded);
		repeat (ResetCycles + vecCount * CyclesPerVector)
			@(posedge iClk);
		$display("run timed out after %0d cycles", ResetCycles + vecCount * CyclesPerVector);
		$display("Some tests failed");
		$finish;
	end

	initial
	begin
		iClk = 1'b0;
		iRst_N = 1'b0;
		opCode = opIdle;
		address = '0;
		wrData = '0;
		psramIn = '0;
		curOp = opIdle;
		curAddr = '0;
		curData = '0;
		curPair = '0;
		heldWord = '0;
		heldValid = 1'b0;
		monitorOn = 1'b0;
		prevCeN = 1'b1;
		frameIdx = 0;
		busErrors = 0;
		ebrErrors = 0;
		wordErrors = 0;
		otherErrors = 0;
		void'($urandom(32'haf66_18ca));
		loadVectors();
		loaded = 1'b1;
		repeat (ResetCycles)
			@(posedge iClk);
		#1;
		iRst_N = 1'b1;
		monitorOn = 1'b1;
		for (int i = 0; i < vecCount; i++)
			runOp(i);
		$display("errors: bus %0d, ebr %0d, word %0d, other %0d",
			busErrors, ebrErrors, wordErrors, otherErrors);
		if (busErrors + ebrErrors + wordErrors + otherErrors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- verif/octalRam_checker.sv
module octalRam_checker (
	input logic iClk,
	input logic iRst_N,
	input logic opDone,
	input octalRamPkg::psramBus_t psramOut,
	input octalRamPkg::ebrWrite_t ebrWr
);

	// done is a single-cycle pulse.
	property donePulse;
		@(posedge iClk) disable iff (!iRst_N)
		opDone |=> !opDone;
	endproperty

	// dq is only driven inside a frame.
	property dqInFrame;
		@(posedge iClk) disable iff (!iRst_N)
		psramOut.ceN |-> !psramOut.dqOe;
	endproperty

	// captures land while the frame is still open.
	property ebrInFrame;
		@(posedge iClk) disable iff (!iRst_N)
		psramOut.ceN |-> !ebrWr.en;
	endproperty

	aDonePulse: assert property (donePulse) else $error("opDone stayed high for two cycles.");
	aDqInFrame: assert property (dqInFrame) else $error("dqOe high while ceN is high.");
	aEbrInFrame: assert property (ebrInFrame) else $error("block ram write while ceN is high.");

endmodule

//--- verif/octalRam_vectors.txt
# columns, all hex: op address data rise fall
# op 1 reset ic, 2 mode write, 3 mode read, 4 burst write, 5 burst read
1 00000000 0000 00 00
2 00000000 0000 00 00
3 00000000 0000 00 a7
4 00001000 beef 00 00
5 00001000 0000 be ef
4 12345678 a55a 00 00
5 12345678 0000 5a a5
3 00000000 0000 11 3c
4 fedcba98 0001 00 00
2 00000000 0000 00 00
5 0badf00d 0000 c3 96
4 80000001 8000 00 00
3 00000000 0000 ff 00
5 00000020 0000 01 80
4 00000000 0000 00 00
5 7f7f7f7f 0000 e1 1e
1 00000000 0000 00 00
4 00ab00cd 1234 00 00
